/* Bender.yml */
package:
  name: eth_rx

export_include_dirs:
  - src

sources:
  - files:
      - src/rmii_pkg.sv
      - src/rmii_rx.sv
      - src/bit_order.sv
      - src/frame_filter.sv
      - src/word_packer.sv
      - src/fcs_check.sv
      - src/eth_rx_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_eth_rx.sv

/* all.f */
+incdir+src
src/rmii_pkg.sv
src/rmii_rx.sv
src/bit_order.sv
src/frame_filter.sv
src/word_packer.sv
src/fcs_check.sv
src/eth_rx_top.sv
verification/tb_eth_rx.sv

/* src/bit_order.sv */
`timescale 1ns/1ps

module bit_order (
    input  logic             clk_50mhz,
    input  logic             rst,
    input  logic             in_valid,
    input  rmii_pkg::dibit_t in_dibit,
    output logic             out_valid,
    output rmii_pkg::dibit_t out_dibit
);
    import rmii_pkg::*;

    logic [1:0] pos;     // dibit position within the byte
    logic [1:0] rem;     // replay dibits still to send
    dibit_t     cap [3]; // first three dibits of the byte being captured
    dibit_t     rep [3];
    logic       load;

    // last dibit of a byte goes straight out as the msb dibit
    assign load = in_valid && (pos == 2'd3);

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            pos       <= 2'd0;
            rem       <= 2'd0;
            out_valid <= 1'b0;
        end else begin
            pos <= in_valid ? pos + 2'd1 : 2'd0;
            if (load) begin
                rem       <= 2'd3;
                out_valid <= 1'b1;
            end else if (rem != 2'd0) begin
                rem       <= rem - 2'd1;
                out_valid <= 1'b1;
            end else begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (in_valid && pos != 2'd3) begin
            cap[pos] <= in_dibit;
        end
        if (load) begin
            out_dibit <= in_dibit;
            rep[0]    <= cap[0];
            rep[1]    <= cap[1];
            rep[2]    <= cap[2];
        end else if (rem != 2'd0) begin
            out_dibit <= rep[rem - 2'd1]; // rep[2] first, down to rep[0]
        end
    end

endmodule

/* src/eth_rx_top.sv */
`timescale 1ns/1ps
`include "rmii_consts.svh"

module eth_rx_top (
    input  logic              clk_50mhz,
    input  logic              rst,
    input  logic              crsdv,
    input  logic [1:0]        rxd,
    output logic              word_valid,
    output logic [31:0]       word_data,
    output logic [`CNT_W-1:0] good_frames,
    output logic [`CNT_W-1:0] bad_frames
);
    import rmii_pkg::*;

    logic   frame_valid;
    dibit_t frame_dibit;
    logic   ord_valid;
    dibit_t ord_dibit;
    logic   pay_valid;
    dibit_t pay_dibit;
    logic   accepted;
    logic   fcs_done;
    logic   fcs_kill;

    rmii_rx rmii_rx_i (
        .clk_50mhz   (clk_50mhz),
        .rst         (rst),
        .crsdv       (crsdv),
        .rxd         (rxd),
        .frame_valid (frame_valid),
        .frame_dibit (frame_dibit)
    );

    bit_order bit_order_i (
        .clk_50mhz (clk_50mhz),
        .rst       (rst),
        .in_valid  (frame_valid),
        .in_dibit  (frame_dibit),
        .out_valid (ord_valid),
        .out_dibit (ord_dibit)
    );

    frame_filter frame_filter_i (
        .clk_50mhz (clk_50mhz),
        .rst       (rst),
        .in_valid  (ord_valid),
        .in_dibit  (ord_dibit),
        .pay_valid (pay_valid),
        .pay_dibit (pay_dibit),
        .accepted  (accepted)
    );

    word_packer word_packer_i (
        .clk_50mhz  (clk_50mhz),
        .rst        (rst),
        .in_valid   (pay_valid),
        .in_dibit   (pay_dibit),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    // crc runs on the raw lsb-first stream, before any reordering
    fcs_check fcs_check_i (
        .clk_50mhz (clk_50mhz),
        .rst       (rst),
        .in_valid  (frame_valid),
        .in_dibit  (frame_dibit),
        .done      (fcs_done),
        .kill      (fcs_kill)
    );

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            good_frames <= '0;
            bad_frames  <= '0;
        end else if (fcs_done && accepted) begin // filtered frames not counted
            if (fcs_kill) begin
                bad_frames <= bad_frames + 1'b1;
            end else begin
                good_frames <= good_frames + 1'b1;
            end
        end
    end

endmodule

/* src/fcs_check.sv */
`timescale 1ns/1ps

module fcs_check (
    input  logic             clk_50mhz,
    input  logic             rst,
    input  logic             in_valid,
    input  rmii_pkg::dibit_t in_dibit,
    output logic             done,
    output logic             kill
);
    import rmii_pkg::*;

    logic [31:0] crc;
    logic        prev_valid;
    logic [31:0] crc_base;
    logic        frame_end;

    // two bits per clock, rxd[0] first
    function automatic logic [31:0] crc_dibit(input logic [31:0] crc_in, input dibit_t d);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 2; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_base  = prev_valid ? crc : 32'hFFFF_FFFF; // preset on first dibit
    assign frame_end = prev_valid && !in_valid;

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            prev_valid <= 1'b0;
            done       <= 1'b0;
            kill       <= 1'b0;
        end else begin
            prev_valid <= in_valid;
            done       <= frame_end;
            kill       <= frame_end && (crc != FCS_RESIDUE);
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (in_valid) begin
            crc <= crc_dibit(crc_base, in_dibit);
        end
    end

endmodule

/* src/frame_filter.sv */
`timescale 1ns/1ps
`include "rmii_consts.svh"

module frame_filter (
    input  logic             clk_50mhz,
    input  logic             rst,
    input  logic             in_valid,
    input  rmii_pkg::dibit_t in_dibit,
    output logic             pay_valid,
    output rmii_pkg::dibit_t pay_dibit,
    output logic             accepted
);
    import rmii_pkg::*;

    localparam int HDR_DIBITS = `HDR_BYTES * 4;
    localparam int MAC_DIBITS = 24;
    localparam int CNT_BITS   = $clog2(HDR_DIBITS + 1);

    localparam logic [47:0] OWN   = `OWN_MAC;
    localparam logic [47:0] BCAST = `BCAST_MAC;

    logic [CNT_BITS-1:0] cnt;    // dibits seen so far, sticks at HDR_DIBITS
    logic                own_ok;
    logic                bc_ok;
    logic                first;
    logic [47:0]         own_sh;
    logic [47:0]         bc_sh;
    dibit_t              own_exp;
    dibit_t              bc_exp;
    logic                own_hit;
    logic                bc_hit;

    // expected address dibit for the current position, msb first
    always_comb begin
        first   = (cnt == '0);
        own_sh  = OWN << {cnt, 1'b0};
        bc_sh   = BCAST << {cnt, 1'b0};
        own_exp = own_sh[47:46];
        bc_exp  = bc_sh[47:46];
        own_hit = (in_dibit == own_exp) && (first || own_ok);
        bc_hit  = (in_dibit == bc_exp) && (first || bc_ok);
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            cnt       <= '0;
            own_ok    <= 1'b0;
            bc_ok     <= 1'b0;
            accepted  <= 1'b0;
            pay_valid <= 1'b0;
        end else begin
            pay_valid <= in_valid && accepted && (cnt == HDR_DIBITS);
            if (!in_valid) begin
                cnt <= '0;
            end else begin
                if (cnt != HDR_DIBITS) begin
                    cnt <= cnt + 1'b1;
                end
                if (cnt < MAC_DIBITS) begin
                    own_ok <= own_hit;
                    bc_ok  <= bc_hit;
                end
                if (first) begin
                    accepted <= 1'b0; // new frame, forget the last verdict
                end else if (cnt == MAC_DIBITS - 1) begin
                    accepted <= own_hit || bc_hit;
                end
            end
        end
    end

    always_ff @(posedge clk_50mhz) begin
        pay_dibit <= in_dibit;
    end

endmodule

/* src/rmii_consts.svh */
`ifndef RMII_CONSTS_SVH
`define RMII_CONSTS_SVH

// station address, first byte on the wire in bits 47:40
`define OWN_MAC 48'h02_00_5E_10_20_30

`define BCAST_MAC 48'hFF_FF_FF_FF_FF_FF

// dst mac + src mac + ethertype
`define HDR_BYTES 14

// good / bad frame counter width
`define CNT_W 16

`endif

/* src/rmii_pkg.sv */
package rmii_pkg;

    // one rmii transfer, rxd[0] is the earlier bit on the wire
    typedef logic [1:0] dibit_t;

    // packed payload word, first network byte in the top bits
    typedef logic [31:0] word_t;

    localparam dibit_t IDLE_DIBIT = 2'b00; // carrier up, no preamble yet
    localparam dibit_t PRE_DIBIT  = 2'b01; // 0x55 preamble, sent lsb first
    localparam dibit_t SFD_DIBIT  = 2'b11; // last dibit of 0xd5

    // ieee 802.3 crc-32, reflected form
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    // register value left after clocking a frame plus its own fcs
    localparam logic [31:0] FCS_RESIDUE = 32'hDEBB_20E3;

endpackage

/* src/rmii_rx.sv */
`timescale 1ns/1ps

module rmii_rx (
    input  logic             clk_50mhz,
    input  logic             rst,
    input  logic             crsdv,
    input  rmii_pkg::dibit_t rxd,
    output logic             frame_valid,
    output rmii_pkg::dibit_t frame_dibit
);
    import rmii_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        DATA
    } state_t;

    state_t state;
    logic   skip; // preamble was broken, sit out the rest of this carrier

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            state       <= IDLE;
            skip        <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= (state == DATA) && crsdv;
            if (!crsdv) begin
                state <= IDLE; // carrier gone ends everything
                skip  <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        if (!skip) begin
                            if (rxd == PRE_DIBIT) begin
                                state <= PREAMBLE;
                            end else if (rxd != IDLE_DIBIT) begin
                                skip <= 1'b1;
                            end
                        end
                    end
                    PREAMBLE: begin
                        if (rxd == SFD_DIBIT) begin
                            state <= DATA; // next dibit is the first frame dibit
                        end else if (rxd != PRE_DIBIT) begin
                            state <= IDLE;
                            skip  <= 1'b1;
                        end
                    end
                    DATA: begin
                        state <= DATA; // held until crsdv drops
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // data path, qualified by frame_valid
    always_ff @(posedge clk_50mhz) begin
        frame_dibit <= rxd;
    end

endmodule

/* src/word_packer.sv */
`timescale 1ns/1ps

module word_packer (
    input  logic             clk_50mhz,
    input  logic             rst,
    input  logic             in_valid,
    input  rmii_pkg::dibit_t in_dibit,
    output logic             word_valid,
    output rmii_pkg::word_t  word_data
);
    import rmii_pkg::*;

    word_t      sh;    // shift register, msb first
    logic [3:0] cnt;   // dibits in the current word
    word_t      hold;  // last complete word, sent once another completes
    logic       held;
    logic       full;
    word_t      next_word;

    assign full      = in_valid && (cnt == 4'd15);
    assign next_word = {sh[29:0], in_dibit};

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            cnt        <= 4'd0;
            held       <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= full && held;
            if (!in_valid) begin
                cnt  <= 4'd0;
                held <= 1'b0; // fcs word and any tail are dropped here
            end else begin
                cnt <= cnt + 4'd1;
                if (full) begin
                    held <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (in_valid) begin
            sh <= next_word;
        end
        if (full) begin
            hold      <= next_word;
            word_data <= hold;
        end
    end

endmodule

/* verification/tb_eth_rx.sv */
`timescale 1ns/1ps
`include "rmii_consts.svh"

module tb_eth_rx;

    localparam int          NUM_FRAMES  = 8;
    localparam int          GAP_DIBITS  = 12;
    localparam logic [31:0] CRC32_POLY  = 32'hEDB8_8320; // reflected 802.3 polynomial
    localparam logic [47:0] FOREIGN_MAC = 48'h02_00_5E_10_20_31;
    localparam logic [47:0] SRC_MAC     = 48'h02_11_22_33_44_55;

    int pay_len  [NUM_FRAMES] = '{32, 16, 16, 24, 16, 20, 8, 12}; // payload bytes
    int dst_sel  [NUM_FRAMES] = '{0, 1, 2, 0, 0, 0, 1, 0}; // 0 own, 1 broadcast, 2 foreign
    bit fcs_flip [NUM_FRAMES] = '{0, 0, 0, 1, 0, 0, 0, 0};
    bit pre_bad  [NUM_FRAMES] = '{0, 0, 0, 0, 1, 0, 0, 0}; // dibit 2 inside the preamble

    logic              clk_50mhz;
    logic              rst;
    logic              crsdv;
    logic [1:0]        rxd;
    logic              word_valid;
    logic [31:0]       word_data;
    logic [`CNT_W-1:0] good_frames;
    logic [`CNT_W-1:0] bad_frames;

    logic [7:0]  frame_buf [0:255]; // header, payload and fcs of the frame being sent
    int          frame_len;
    logic [31:0] exp_q [$];
    logic [31:0] exp_word;
    logic [31:0] lcg_state;
    int          exp_good;
    int          exp_bad;
    int          cycles;
    int          cycle_limit;

    eth_rx_top eth_rx_top_i (
        .clk_50mhz   (clk_50mhz),
        .rst         (rst),
        .crsdv       (crsdv),
        .rxd         (rxd),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

    initial clk_50mhz = 1'b0;
    always #10 clk_50mhz = ~clk_50mhz;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // bitwise crc-32 lsb first from an all ones preset without final inversion
    function automatic logic [31:0] crc_over(input int count);
        logic [31:0] c;
        logic [7:0]  b;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < count; i++) begin
            b = frame_buf[i];
            for (int k = 0; k < 8; k++) begin
                if (c[0] ^ b[k]) begin
                    c = (c >> 1) ^ CRC32_POLY;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return c;
    endfunction

    // first byte lands in the top bits
    function automatic logic [31:0] pack_word(input int start);
        return {frame_buf[start], frame_buf[start + 1],
                frame_buf[start + 2], frame_buf[start + 3]};
    endfunction

    task automatic put_byte(input logic [7:0] b);
        frame_buf[frame_len] = b;
        frame_len = frame_len + 1;
    endtask

    task automatic send_dibit(input logic cs, input logic [1:0] d);
        @(negedge clk_50mhz);
        crsdv = cs;
        rxd   = d;
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int k = 0; k < 4; k++) begin
            send_dibit(1'b1, b[2*k +: 2]); // lsb dibit first
        end
    endtask

    task automatic send_frame(input int idx);
        logic [47:0] dst;
        logic [31:0] fcs;
        bit          take;
        bit          fcs_good;
        frame_len = 0;
        case (dst_sel[idx])
            0:       dst = `OWN_MAC;
            1:       dst = `BCAST_MAC;
            default: dst = FOREIGN_MAC;
        endcase
        for (int i = 0; i < 6; i++) begin
            put_byte(dst[47 - 8*i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            put_byte(SRC_MAC[47 - 8*i -: 8]);
        end
        put_byte(8'h08);
        put_byte(8'h00);
        for (int i = 0; i < pay_len[idx]; i++) begin
            lcg_state = lcg_next(lcg_state);
            put_byte(lcg_state[23:16]);
        end
        fcs = ~crc_over(frame_len);
        if (fcs_flip[idx]) begin
            fcs[8] = ~fcs[8];
        end
        for (int i = 0; i < 4; i++) begin
            put_byte(fcs[8*i +: 8]);
        end
        fcs_good = !fcs_flip[idx];
        take     = ((dst == `OWN_MAC) || (dst == `BCAST_MAC)) && !pre_bad[idx];
        if (take) begin
            for (int w = 0; w < pay_len[idx] / 4; w++) begin
                exp_q.push_back(pack_word(`HDR_BYTES + 4*w));
            end
        end
        for (int i = 0; i < 7; i++) begin
            send_byte((pre_bad[idx] && i == 3) ? 8'h59 : 8'h55); // 0x59 puts a 2 mid preamble
        end
        send_byte(8'hD5);
        for (int i = 0; i < frame_len; i++) begin
            send_byte(frame_buf[i]);
        end
        repeat (GAP_DIBITS) send_dibit(1'b0, 2'b00);
        if (take && fcs_good) begin
            exp_good = exp_good + 1;
        end else if (take) begin
            exp_bad = exp_bad + 1;
        end
    endtask

    task automatic check_counts();
        assert (good_frames == exp_good) else
            stop_run($sformatf("FAIL %0t good_frames expected %0d got %0d",
                               $time, exp_good, good_frames));
        assert (bad_frames == exp_bad) else
            stop_run($sformatf("FAIL %0t bad_frames expected %0d got %0d",
                               $time, exp_bad, bad_frames));
        assert (exp_q.size() == 0) else
            stop_run($sformatf("%0d expected payload words never came out at %0t",
                               exp_q.size(), $time));
    endtask

    // outputs are stable by the falling edge
    always @(negedge clk_50mhz) begin
        if (!rst && word_valid) begin
            if (exp_q.size() == 0) begin
                stop_run($sformatf("word_valid at %0t with no word expected", $time));
            end else begin
                exp_word = exp_q.pop_front();
                assert (word_data === exp_word) else
                    stop_run($sformatf("FAIL %0t word_data expected %08h got %08h",
                                       $time, exp_word, word_data));
            end
        end
    end

    always @(posedge clk_50mhz) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            stop_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        int total;
        rst         = 1'b1;
        crsdv       = 1'b0;
        rxd         = 2'b00;
        lcg_state   = 32'd96;
        exp_good    = 0;
        exp_bad     = 0;
        cycles      = 0;
        total       = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            total = total + (8 + `HDR_BYTES + pay_len[f] + 4) * 4 + GAP_DIBITS;
        end
        cycle_limit = 2 * total + 200;
        repeat (16) @(negedge clk_50mhz);
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
            check_counts();
        end
        repeat (4) @(negedge clk_50mhz);
        if (exp_q.size() != 0 || good_frames != exp_good || bad_frames != exp_bad) begin
            stop_run("word queue or frame counters wrong at the end of the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
